//--- design/isaPkg.sv
// RV32 subset definitions for the controller
// Word and field types, major opcodes, instruction classes
// and immediate formats
package isaPkg;

    localparam int xlen = 32;       // Register and instruction width
    localparam int opcodeBits = 7;
    localparam int funct3Bits = 3;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [opcodeBits-1:0] opcode_t;
    typedef logic [funct3Bits-1:0] funct3_t;

    // Major opcodes, instr[6:0]
    localparam opcode_t opLoad   = 7'b0000011;  // lw
    localparam opcode_t opStore  = 7'b0100011;  // sw
    localparam opcode_t opRegAlu = 7'b0110011;  // R-type
    localparam opcode_t opImmAlu = 7'b0010011;  // I-type ALU
    localparam opcode_t opJal    = 7'b1101111;
    localparam opcode_t opBranch = 7'b1100011;  // beq

    // One class per sequencer path
    typedef enum logic [2:0] {
        clsLoad,
        clsStore,
        clsRegAlu,
        clsImmAlu,
        clsJal,
        clsBranch,
        clsIllegal
    } instrClass_t;

    // Select for the immediate extender
    typedef enum logic [1:0] {
        immI = 2'b00,
        immS = 2'b01,
        immB = 2'b10,
        immJ = 2'b11
    } immSrc_t;

    typedef struct packed {
        instrClass_t cls;
        funct3_t     funct3;    // Passed on as ALU operation
        immSrc_t     immSrc;
    } decodedInstr_t;

endpackage

//--- design/ctrlPkg.sv
// Memory bus command format, datapath select codes,
// control bundle and sequencer states
package ctrlPkg;

    typedef logic [1:0]  cmdKind_t;
    typedef logic [29:0] cmdPayload_t;

    // 34-bit command toward the bus master
    typedef struct packed {
        cmdKind_t    kind;
        logic        incr;      // Add payload to current address
        logic        autoInc;   // Step address on each read
        cmdPayload_t payload;
    } busCmd_t;

    localparam cmdKind_t cmdSetAddr = 2'b10;
    localparam cmdKind_t cmdRead    = 2'b00;    // Payload ignored

    typedef logic [1:0] aluSrc_t;
    typedef logic [1:0] resSrc_t;
    typedef logic [2:0] aluCtl_t;

    // ALU A mux
    localparam aluSrc_t srcAPc    = 2'b00;
    localparam aluSrc_t srcAOldPc = 2'b01;  // PC of the current instruction
    localparam aluSrc_t srcAReg   = 2'b10;  // rs1

    // ALU B mux
    localparam aluSrc_t srcBReg  = 2'b00;   // rs2
    localparam aluSrc_t srcBImm  = 2'b01;   // Extended immediate
    localparam aluSrc_t srcBFour = 2'b10;

    // Result bus mux
    localparam resSrc_t resAluOut    = 2'b00;   // Registered ALU output
    localparam resSrc_t resData      = 2'b01;   // Memory read data
    localparam resSrc_t resAluResult = 2'b10;   // ALU output this cycle

    localparam aluCtl_t aluAdd = 3'b000;
    localparam aluCtl_t aluSub = 3'b001;

    // Datapath controls, zero means inactive
    typedef struct packed {
        logic            pcWrite;
        logic            adrSrc;    // 1 selects ALU out as memory address
        logic            memWrite;
        logic            regWrite;
        resSrc_t         resultSrc;
        aluSrc_t         aluSrcA;
        aluSrc_t         aluSrcB;
        aluCtl_t         aluControl;
        isaPkg::immSrc_t immSrc;
    } ctrlBundle_t;

    localparam ctrlBundle_t ctrlIdle = '0;

    typedef enum logic [3:0] {
        sFetchIssue,
        sFetchWait,
        sDecode,
        sMemAddr,
        sMemRead,
        sMemWb,
        sMemWrite,
        sExecR,
        sExecI,
        sJal,
        sBeq,
        sAluWb,
        sError
    } seqState_t;

endpackage

//--- design/fetchRequester.sv
// Instruction fetch over the strobe bus
// Set-address command with the PC, then a read command,
// then hands the returned word on with a valid pulse
`timescale 1ns/1ns

module fetchRequester (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 fetchStart,
    input  isaPkg::word_t                        pc,
    input  logic                                 cmdBusy,
    input  logic                                 rspStb,
    input  logic [$bits(ctrlPkg::busCmd_t)-1:0]  rspWord,
    output logic                                 cmdStb,
    output ctrlPkg::busCmd_t                     cmdWord,
    output logic                                 instrValid,
    output isaPkg::word_t                        instrWord
);

    typedef enum logic [2:0] {
        fIdle,
        fSendAddr,
        fGap,       // Strobe cycle of the address command
        fSendRead,
        fWaitRsp
    } fetchStage_t;

    fetchStage_t   stage;
    isaPkg::word_t pcReg;   // PC captured at fetchStart

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            stage      <= fIdle;
            cmdStb     <= 1'b0;
            instrValid <= 1'b0;
        end
        else
        begin
            cmdStb     <= 1'b0; // Strobes are single cycle
            instrValid <= 1'b0;
            case (stage)
                fIdle:
                    if (fetchStart)
                        stage <= fSendAddr;
                fSendAddr:
                    if (!cmdBusy)
                    begin
                        cmdStb <= 1'b1;
                        stage  <= fGap;
                    end
                fGap:
                    stage <= fSendRead;     // Master raises busy meanwhile
                fSendRead:
                    if (!cmdBusy)
                    begin
                        cmdStb <= 1'b1;
                        stage  <= fWaitRsp;
                    end
                fWaitRsp:
                    if (rspStb)
                    begin
                        instrValid <= 1'b1;
                        stage      <= fIdle;
                    end
                default:
                    stage <= fIdle;
            endcase
        end
    end

    // Command and data registers
    always_ff @(posedge clk)
    begin
        if (stage == fIdle && fetchStart)
            pcReg <= pc;
        if (stage == fSendAddr && !cmdBusy)
        begin
            cmdWord.kind    <= ctrlPkg::cmdSetAddr;
            cmdWord.incr    <= 1'b0;                // Absolute address
            cmdWord.autoInc <= 1'b0;
            cmdWord.payload <= pcReg[29:0];
        end
        else if (stage == fSendRead && !cmdBusy)
        begin
            cmdWord.kind    <= ctrlPkg::cmdRead;
            cmdWord.incr    <= 1'b0;
            cmdWord.autoInc <= 1'b0;
            cmdWord.payload <= '0;
        end
        if (stage == fWaitRsp && rspStb)
            instrWord <= rspWord[isaPkg::xlen-1:0]; // Instruction in low word
    end

endmodule

//--- design/instrBuffer.sv
// Instruction register and class decode
// Holds the fetched word and derives class, funct3 and immediate type
`timescale 1ns/1ns

module instrBuffer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  instrValid,
    input  isaPkg::word_t         instrWord,
    output isaPkg::decodedInstr_t decoded,
    output isaPkg::word_t         instr
);

    isaPkg::word_t   instrReg;
    isaPkg::opcode_t opcode;

    // Loaded once per fetch
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            instrReg <= '0;     // Opcode 0 decodes as illegal
        else if (instrValid)
            instrReg <= instrWord;
    end

    assign instr  = instrReg;
    assign opcode = instrReg[6:0];

    always_comb
    begin
        decoded.funct3 = instrReg[14:12];
        case (opcode)
            isaPkg::opLoad:   decoded.cls = isaPkg::clsLoad;
            isaPkg::opStore:  decoded.cls = isaPkg::clsStore;
            isaPkg::opRegAlu: decoded.cls = isaPkg::clsRegAlu;
            isaPkg::opImmAlu: decoded.cls = isaPkg::clsImmAlu;
            isaPkg::opJal:    decoded.cls = isaPkg::clsJal;
            isaPkg::opBranch: decoded.cls = isaPkg::clsBranch;
            default:          decoded.cls = isaPkg::clsIllegal;
        endcase

        // Immediate layout per class
        case (decoded.cls)
            isaPkg::clsStore:  decoded.immSrc = isaPkg::immS;
            isaPkg::clsBranch: decoded.immSrc = isaPkg::immB;
            isaPkg::clsJal:    decoded.immSrc = isaPkg::immJ;
            // lw and I-type use I
            // R-type has no immediate
            default:           decoded.immSrc = isaPkg::immI;
        endcase
    end

endmodule

//--- design/stepSequencer.sv
// Multicycle control FSM
// Walks fetch, decode and the per-class states and drives
// the datapath control bundle
`timescale 1ns/1ns

module stepSequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  instrValid,
    input  isaPkg::decodedInstr_t decoded,
    input  logic                  zero,
    output logic                  fetchStart,
    output ctrlPkg::ctrlBundle_t  ctrl
);

    ctrlPkg::seqState_t state;
    ctrlPkg::seqState_t nextState;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= ctrlPkg::sFetchIssue;
        else
            state <= nextState;
    end

    // Next state
    always_comb
    begin
        nextState = state;
        case (state)
            ctrlPkg::sFetchIssue:
                nextState = ctrlPkg::sFetchWait;
            ctrlPkg::sFetchWait:
                if (instrValid)
                    nextState = ctrlPkg::sDecode;   // Buffer loads on this edge
            ctrlPkg::sDecode:
                case (decoded.cls)
                    isaPkg::clsLoad,
                    isaPkg::clsStore:  nextState = ctrlPkg::sMemAddr;
                    isaPkg::clsRegAlu: nextState = ctrlPkg::sExecR;
                    isaPkg::clsImmAlu: nextState = ctrlPkg::sExecI;
                    isaPkg::clsJal:    nextState = ctrlPkg::sJal;
                    isaPkg::clsBranch: nextState = ctrlPkg::sBeq;
                    default:           nextState = ctrlPkg::sError;
                endcase
            ctrlPkg::sMemAddr:
                if (decoded.cls == isaPkg::clsLoad)
                    nextState = ctrlPkg::sMemRead;
                else if (decoded.cls == isaPkg::clsStore)
                    nextState = ctrlPkg::sMemWrite;
                else
                    nextState = ctrlPkg::sError;
            ctrlPkg::sMemRead:
                nextState = ctrlPkg::sMemWb;
            ctrlPkg::sExecR,
            ctrlPkg::sExecI,
            ctrlPkg::sJal:
                nextState = ctrlPkg::sAluWb;
            ctrlPkg::sMemWb,
            ctrlPkg::sMemWrite,
            ctrlPkg::sBeq,
            ctrlPkg::sAluWb:
                nextState = ctrlPkg::sFetchIssue;
            ctrlPkg::sError:
                nextState = ctrlPkg::sError;    // Held until reset
            default:
                nextState = ctrlPkg::sError;
        endcase
    end

    assign fetchStart = (state == ctrlPkg::sFetchIssue);

    // Outputs from state, plus zero in sBeq
    always_comb
    begin
        ctrl = ctrlPkg::ctrlIdle;
        case (state)
            ctrlPkg::sFetchIssue:
            begin
                // PC <- PC + 4
                ctrl.pcWrite    = 1'b1;
                ctrl.aluSrcA    = ctrlPkg::srcAPc;
                ctrl.aluSrcB    = ctrlPkg::srcBFour;
                ctrl.aluControl = ctrlPkg::aluAdd;
                ctrl.resultSrc  = ctrlPkg::resAluResult;
            end
            ctrlPkg::sDecode:
            begin
                // Branch or jump target into ALUOut
                ctrl.aluSrcA    = ctrlPkg::srcAOldPc;
                ctrl.aluSrcB    = ctrlPkg::srcBImm;
                ctrl.aluControl = ctrlPkg::aluAdd;
                ctrl.immSrc     = decoded.immSrc;
            end
            ctrlPkg::sMemAddr:
            begin
                ctrl.aluSrcA    = ctrlPkg::srcAReg;     // rs1 + offset
                ctrl.aluSrcB    = ctrlPkg::srcBImm;
                ctrl.aluControl = ctrlPkg::aluAdd;
                ctrl.immSrc     = decoded.immSrc;       // I for lw, S for sw
            end
            ctrlPkg::sMemRead:
                ctrl.adrSrc = 1'b1;     // Address from ALUOut
            ctrlPkg::sMemWb:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = ctrlPkg::resData;
            end
            ctrlPkg::sMemWrite:
            begin
                ctrl.memWrite = 1'b1;
                ctrl.adrSrc   = 1'b1;
            end
            ctrlPkg::sExecR:
            begin
                ctrl.aluSrcA    = ctrlPkg::srcAReg;
                ctrl.aluSrcB    = ctrlPkg::srcBReg;
                ctrl.aluControl = decoded.funct3;
            end
            ctrlPkg::sExecI:
            begin
                ctrl.aluSrcA    = ctrlPkg::srcAReg;
                ctrl.aluSrcB    = ctrlPkg::srcBImm;
                ctrl.aluControl = decoded.funct3;
                ctrl.immSrc     = isaPkg::immI;
            end
            ctrlPkg::sJal:
            begin
                // PC <- target, ALUOut <- old PC + 4 as link
                ctrl.pcWrite    = 1'b1;
                ctrl.aluSrcA    = ctrlPkg::srcAOldPc;
                ctrl.aluSrcB    = ctrlPkg::srcBFour;
                ctrl.aluControl = ctrlPkg::aluAdd;
                ctrl.resultSrc  = ctrlPkg::resAluOut;
            end
            ctrlPkg::sBeq:
            begin
                ctrl.aluSrcA    = ctrlPkg::srcAReg;     // rs1 - rs2
                ctrl.aluSrcB    = ctrlPkg::srcBReg;
                ctrl.aluControl = ctrlPkg::aluSub;
                ctrl.resultSrc  = ctrlPkg::resAluOut;   // Target from decode
                ctrl.pcWrite    = zero;                 // Taken only if equal
            end
            ctrlPkg::sAluWb:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = ctrlPkg::resAluOut;
            end
            default:
                ctrl = ctrlPkg::ctrlIdle;   // sFetchWait and sError
        endcase
    end

endmodule

//--- design/multicycleController.sv
// Controller top
// Fetch requester, instruction buffer and step sequencer
`timescale 1ns/1ns

module multicycleController (
    input  logic                                 clk,
    input  logic                                 reset,
    input  isaPkg::word_t                        pc,
    input  logic                                 zero,
    input  logic                                 cmdBusy,
    input  logic                                 rspStb,
    input  logic [$bits(ctrlPkg::busCmd_t)-1:0]  rspWord,
    output logic                                 cmdStb,
    output ctrlPkg::busCmd_t                     cmdWord,
    output ctrlPkg::ctrlBundle_t                 ctrl,
    output isaPkg::word_t                        instr
);

    logic                  fetchStart;  // Sequencer to requester
    logic                  instrValid;
    isaPkg::word_t         instrWord;
    isaPkg::decodedInstr_t decoded;

    fetchRequester fetch_i (
        .clk        (clk),
        .reset      (reset),
        .fetchStart (fetchStart),
        .pc         (pc),
        .cmdBusy    (cmdBusy),
        .rspStb     (rspStb),
        .rspWord    (rspWord),
        .cmdStb     (cmdStb),
        .cmdWord    (cmdWord),
        .instrValid (instrValid),
        .instrWord  (instrWord)
    );

    instrBuffer ibuf_i (
        .clk        (clk),
        .reset      (reset),
        .instrValid (instrValid),
        .instrWord  (instrWord),
        .decoded    (decoded),
        .instr      (instr)
    );

    stepSequencer seq_i (
        .clk        (clk),
        .reset      (reset),
        .instrValid (instrValid),
        .decoded    (decoded),
        .zero       (zero),
        .fetchStart (fetchStart),
        .ctrl       (ctrl)
    );

endmodule

//--- test/controllerTb.sv
// Testbench for the multicycle controller
// Bus model with random busy time, directed tests per instruction class,
// compare tasks, cycle limit and summary
`timescale 1ns/1ns

module controllerTb;

    localparam int numTests   = 6;
    localparam int cycleLimit = numTests * 40 + 100;
    localparam isaPkg::word_t nopWord = 32'h00000013;  // addi x0, x0, 0

    logic                                clk;
    logic                                reset;
    isaPkg::word_t                       pc;
    logic                                zero;
    logic                                cmdBusy;
    logic                                rspStb;
    logic [$bits(ctrlPkg::busCmd_t)-1:0] rspWord;
    logic                                cmdStb;
    ctrlPkg::busCmd_t                    cmdWord;
    ctrlPkg::ctrlBundle_t                ctrl;
    isaPkg::word_t                       instr;

    isaPkg::word_t    progQ[$];     // Words for upcoming reads
    ctrlPkg::busCmd_t cmdLog[$];    // Every command seen
    int               busyLeft;
    logic             rspPending;   // Read accepted with answer due
    logic             popped;       // Answer came from progQ
    logic [7:0]       lfsrState;
    int               cycle;
    int               errors;
    int               testErrors;
    int               testsOk;
    string            testName;

    multicycleController dut_i (
        .clk     (clk),
        .reset   (reset),
        .pc      (pc),
        .zero    (zero),
        .cmdBusy (cmdBusy),
        .rspStb  (rspStb),
        .rspWord (rspWord),
        .cmdStb  (cmdStb),
        .cmdWord (cmdWord),
        .ctrl    (ctrl),
        .instr   (instr)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #50 clk = ~clk;     // 100 ns period
    end

    // Run limit on the tick count
    always @(posedge clk)
    begin
        if (cycle >= cycleLimit)
        begin
            $display("Timeout after %0d cycles in %s", cycleLimit, testName);
            $display("Test failed");
            $finish;
        end
    end

    // 8-bit Fibonacci LFSR with taps 8 6 5 4
    function automatic logic [3:0] randBits(int n);
        logic [3:0] r;
        logic       fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb        = lfsrState[7] ^ lfsrState[5] ^ lfsrState[4] ^ lfsrState[3];
            lfsrState = {lfsrState[6:0], fb};
            r         = {r[2:0], fb};
        end
        return r;
    endfunction

    function automatic ctrlPkg::ctrlBundle_t makeBundle(
        logic pcWrite, logic adrSrc, logic memWrite, logic regWrite,
        ctrlPkg::resSrc_t resultSrc, ctrlPkg::aluSrc_t aluSrcA, ctrlPkg::aluSrc_t aluSrcB,
        ctrlPkg::aluCtl_t aluControl, isaPkg::immSrc_t immSrc);
        return '{pcWrite, adrSrc, memWrite, regWrite, resultSrc, aluSrcA, aluSrcB,
                 aluControl, immSrc};
    endfunction

    // PC + 4 in the fetch issue cycle
    function automatic ctrlPkg::ctrlBundle_t fetchBundle();
        return makeBundle(1'b1, 1'b0, 1'b0, 1'b0, ctrlPkg::resAluResult, ctrlPkg::srcAPc,
                          ctrlPkg::srcBFour, ctrlPkg::aluAdd, isaPkg::immI);
    endfunction

    function automatic ctrlPkg::ctrlBundle_t decodeBundle(isaPkg::immSrc_t imm);
        return makeBundle(1'b0, 1'b0, 1'b0, 1'b0, ctrlPkg::resAluOut, ctrlPkg::srcAOldPc,
                          ctrlPkg::srcBImm, ctrlPkg::aluAdd, imm);  // Target add
    endfunction

    function automatic ctrlPkg::ctrlBundle_t aluWbBundle();
        return makeBundle(1'b0, 1'b0, 1'b0, 1'b1, ctrlPkg::resAluOut, ctrlPkg::srcAPc,
                          ctrlPkg::srcBReg, ctrlPkg::aluAdd, isaPkg::immI);
    endfunction

    task automatic reportWrong(string what, string expected, string actual);
        errors++;
        testErrors++;
        $display("FAIL %s %s: expected %s actual %s", testName, what, expected, actual);
    endtask

    task automatic checkBundle(string what, ctrlPkg::ctrlBundle_t expected,
                               ctrlPkg::ctrlBundle_t actual);
        if (actual !== expected)
            reportWrong(what, $sformatf("%h", expected), $sformatf("%h", actual));
    endtask

    task automatic checkCmd(string what, ctrlPkg::busCmd_t expected, ctrlPkg::busCmd_t actual);
        if (actual !== expected)
            reportWrong(what, $sformatf("%h", expected), $sformatf("%h", actual));
    endtask

    task automatic checkWord(string what, isaPkg::word_t expected, isaPkg::word_t actual);
        if (actual !== expected)
            reportWrong(what, $sformatf("%h", expected), $sformatf("%h", actual));
    endtask

    task automatic checkBit(string what, logic expected, logic actual);
        if (actual !== expected)
            reportWrong(what, $sformatf("%b", expected), $sformatf("%b", actual));
    endtask

    task automatic checkCount(string what, int expected, int actual);
        if (actual != expected)
            reportWrong(what, $sformatf("%0d", expected), $sformatf("%0d", actual));
    endtask

    // Memory master stepped once per cycle
    task automatic busStep();
        isaPkg::word_t w;
        rspStb = 1'b0;      // Single cycle answer
        popped = 1'b0;
        if (cmdStb)
        begin
            if (cmdBusy)
            begin
                errors++;
                testErrors++;
                $display("Error in %s: command strobe while cmdBusy was high", testName);
            end
            cmdLog.push_back(cmdWord);
            cmdBusy  = 1'b1;
            busyLeft = 1 + int'(randBits(2));   // 1 to 4 busy cycles
            if (cmdWord.kind == ctrlPkg::cmdRead)
                rspPending = 1'b1;
        end
        else if (busyLeft > 0)
        begin
            busyLeft--;
            if (busyLeft == 0)
            begin
                cmdBusy = 1'b0;
                if (rspPending)
                begin
                    rspPending = 1'b0;
                    popped     = (progQ.size() > 0);
                    w          = popped ? progQ.pop_front() : nopWord;
                    rspWord    = {2'b11, w};    // Upper bits are not part of the word
                    rspStb     = 1'b1;
                end
            end
        end
    endtask

    // Inputs change 10 ns after the rising edge when outputs have settled
    task automatic tick();
        @(posedge clk);
        #10;
        cycle++;
        busStep();
    endtask

    task automatic applyReset();
        reset      = 1'b1;
        cmdBusy    = 1'b0;
        busyLeft   = 0;
        rspPending = 1'b0;
        repeat (10)
            tick();
        checkBit("cmdStb in reset", 1'b0, cmdStb);
        checkBundle("ctrl in reset", fetchBundle(), ctrl);   // Reset state is fetch issue
        reset = 1'b0;
    endtask

    // Returns in the instrValid cycle of the queued word
    task automatic fetchInstr(isaPkg::word_t w);
        progQ.push_back(w);
        tick();
        while (!(rspStb && popped))
            tick();
        tick();
    endtask

    task automatic startTest(string name);
        testName   = name;
        testErrors = 0;
    endtask

    task automatic endTest();
        if (testErrors == 0)
        begin
            testsOk++;
            $display("%s: ok", testName);
        end
        else
            $display("%s: %0d errors", testName, testErrors);
    endtask

    task automatic resetAndFetch();
        ctrlPkg::busCmd_t expAddr;
        ctrlPkg::busCmd_t expRead;
        startTest("resetAndFetch");
        expAddr = '{ctrlPkg::cmdSetAddr, 1'b0, 1'b0, pc[29:0]};
        expRead = '{ctrlPkg::cmdRead, 1'b0, 1'b0, 30'd0};
        applyReset();
        cmdLog.delete();
        fetchInstr(32'h00100093);   // addi x1, x0, 1
        checkCount("commands per fetch", 2, cmdLog.size());
        if (cmdLog.size() >= 2)
        begin
            checkCmd("address command", expAddr, cmdLog[0]);
            checkCmd("read command", expRead, cmdLog[1]);
        end
        tick();
        checkWord("instr", 32'h00100093, instr);
        endTest();
    endtask

    task automatic loadSequence();
        startTest("loadSequence");
        fetchInstr(32'h0080A283);   // lw x5, 8(x1)
        tick();
        checkBundle("decode", decodeBundle(isaPkg::immI), ctrl);
        checkWord("instr", 32'h0080A283, instr);
        tick();
        checkBundle("address", makeBundle(1'b0, 1'b0, 1'b0, 1'b0, ctrlPkg::resAluOut,
                    ctrlPkg::srcAReg, ctrlPkg::srcBImm, ctrlPkg::aluAdd, isaPkg::immI), ctrl);
        tick();
        checkBundle("read", makeBundle(1'b0, 1'b1, 1'b0, 1'b0, ctrlPkg::resAluOut,
                    ctrlPkg::srcAPc, ctrlPkg::srcBReg, ctrlPkg::aluAdd, isaPkg::immI), ctrl);
        tick();
        checkBundle("writeback", makeBundle(1'b0, 1'b0, 1'b0, 1'b1, ctrlPkg::resData,
                    ctrlPkg::srcAPc, ctrlPkg::srcBReg, ctrlPkg::aluAdd, isaPkg::immI), ctrl);
        tick();
        checkBundle("next fetch", fetchBundle(), ctrl);
        endTest();
    endtask

    task automatic storeSequence();
        int writes;
        startTest("storeSequence");
        writes = 0;
        fetchInstr(32'h00612623);   // sw x6, 12(x2)
        for (int i = 0; i < 4; i++) // Decode, address, write, next fetch
        begin
            tick();
            if (i == 1)
                checkBundle("address", makeBundle(1'b0, 1'b0, 1'b0, 1'b0, ctrlPkg::resAluOut,
                            ctrlPkg::srcAReg, ctrlPkg::srcBImm, ctrlPkg::aluAdd,
                            isaPkg::immS), ctrl);
            if (ctrl.memWrite)
            begin
                writes++;
                checkBit("adrSrc with memWrite", 1'b1, ctrl.adrSrc);
            end
            checkBit("regWrite", 1'b0, ctrl.regWrite);
        end
        checkCount("memWrite cycles", 1, writes);
        endTest();
    endtask

    task automatic aluCase(isaPkg::word_t word, logic useImm);
        ctrlPkg::aluSrc_t srcB;
        srcB = useImm ? ctrlPkg::srcBImm : ctrlPkg::srcBReg;
        fetchInstr(word);
        tick();
        checkBundle("decode", decodeBundle(isaPkg::immI), ctrl);
        tick();
        checkBundle("execute", makeBundle(1'b0, 1'b0, 1'b0, 1'b0, ctrlPkg::resAluOut,
                    ctrlPkg::srcAReg, srcB, word[14:12], isaPkg::immI), ctrl); // funct3
        tick();
        checkBundle("writeback", aluWbBundle(), ctrl);
    endtask

    task automatic aluSequence();
        startTest("aluSequence");
        aluCase(32'h0020F1B3, 1'b0);    // and x3, x1, x2
        aluCase(32'h0050E213, 1'b1);    // ori x4, x1, 5
        endTest();
    endtask

    task automatic beqCase(logic z);
        fetchInstr(32'h00208463);   // beq x1, x2, 8
        tick();
        checkBundle("beq decode", decodeBundle(isaPkg::immB), ctrl);
        zero = z;
        tick();
        checkBit("beq pcWrite", z, ctrl.pcWrite);
        checkBundle("beq compare", makeBundle(z, 1'b0, 1'b0, 1'b0, ctrlPkg::resAluOut,
                    ctrlPkg::srcAReg, ctrlPkg::srcBReg, ctrlPkg::aluSub, isaPkg::immI), ctrl);
        zero = 1'b0;
    endtask

    task automatic jumpAndBranch();
        startTest("jumpAndBranch");
        fetchInstr(32'h010000EF);   // jal x1, 16
        tick();
        checkBundle("jal decode", decodeBundle(isaPkg::immJ), ctrl);
        tick();
        checkBundle("jal step", makeBundle(1'b1, 1'b0, 1'b0, 1'b0, ctrlPkg::resAluOut,
                    ctrlPkg::srcAOldPc, ctrlPkg::srcBFour, ctrlPkg::aluAdd, isaPkg::immI), ctrl);
        tick();
        checkBundle("jal writeback", aluWbBundle(), ctrl);
        beqCase(1'b1);
        beqCase(1'b0);
        endTest();
    endtask

    task automatic illegalOpcode();
        int strobes;
        startTest("illegalOpcode");
        fetchInstr(32'hFFFFFFFF);   // Opcode 7'h7F is not decoded
        tick();
        strobes = cmdLog.size();
        repeat (20)
        begin
            tick();
            checkBit("cmdStb in error", 1'b0, cmdStb);
            checkBundle("ctrl in error", '0, ctrl);
        end
        checkCount("commands in error", strobes, cmdLog.size());
        applyReset();
        cmdLog.delete();
        fetchInstr(nopWord);
        checkCount("commands after reset", 2, cmdLog.size());
        tick();
        checkWord("instr after reset", nopWord, instr);
        endTest();
    endtask

    initial
    begin
        reset      = 1'b1;
        pc         = 32'hC0000104;  // Top bits fall outside the payload
        zero       = 1'b0;
        cmdBusy    = 1'b0;
        rspStb     = 1'b0;
        rspWord    = '0;
        busyLeft   = 0;
        rspPending = 1'b0;
        popped     = 1'b0;
        lfsrState  = 8'd26;
        cycle      = 0;
        errors     = 0;
        testErrors = 0;
        testsOk    = 0;
        testName   = "startup";
        resetAndFetch();
        loadSequence();
        storeSequence();
        aluSequence();
        jumpAndBranch();
        illegalOpcode();
        $display("Summary: %0d of %0d tests clean, %0d errors, %0d cycles",
                 testsOk, numTests, errors, cycle);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- all.f
design/isaPkg.sv
design/ctrlPkg.sv
design/fetchRequester.sv
design/instrBuffer.sv
design/stepSequencer.sv
design/multicycleController.sv
test/controllerTb.sv

//--- run.sh
#!/bin/sh
# Build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing -f all.f --top-module controllerTb \
    -Mdir "$buildDir" -o controllerSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/controllerSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "Test passed" "$logFile"; then
    exit 0
else
    echo "Pass message not found in $logFile"
    exit 1
fi
